// ==== logic/exc_config.svh ====
`ifndef EXC_CONFIG_SVH
`define EXC_CONFIG_SVH

// Handler base while Status.BEV is set
`define EXC_BOOT_VECTOR 32'hbfc0_0200

// Offsets from the handler base
`define EXC_OFF_REFILL  32'h0000_0000
`define EXC_OFF_GENERAL 32'h0000_0180
`define EXC_OFF_INT     32'h0000_0200

`define EXC_ASID_W 8

// EBase[31:12] after reset, kseg0
`define EXC_EBASE_RESET 20'h8_0000

`endif

// ==== logic/exc_pkg.sv ====
`default_nettype none
`include "exc_config.svh"

package exc_pkg;

    typedef enum logic [2:0] {
        ic_plain,
        ic_load,
        ic_store,
        ic_syscall,
        ic_eret,
        ic_priv_op,   // CP0 access or cache op
        ic_reserved
    } inst_class_e;

    // Cause.ExcCode encodings
    typedef enum logic [4:0] {
        exc_int  = 5'h00,
        exc_mod  = 5'h01,
        exc_tlbl = 5'h02,
        exc_tlbs = 5'h03,
        exc_adel = 5'h04,
        exc_ades = 5'h05,
        exc_sys  = 5'h08,
        exc_ri   = 5'h0a,
        exc_cpu  = 5'h0b,
        exc_ov   = 5'h0c
    } exc_code_e;

    typedef enum logic [2:0] {
        sel_status,
        sel_cause,
        sel_epc,
        sel_badvaddr,
        sel_entryhi,
        sel_ebase
    } cp0_sel_e;

    typedef struct packed {
        logic [31:0]            pc;
        logic                   in_delayslot;
        inst_class_e            inst_class;
        logic [31:0]            mem_vaddr;
        logic                   if_illegal;
        logic                   if_miss;
        logic                   if_invalid;
        logic                   dm_illegal;
        logic                   dm_miss;
        logic                   dm_invalid;
        logic                   dm_dirty;
        logic                   overflow;
        logic [`EXC_ASID_W-1:0] if_asid;
        logic [`EXC_ASID_W-1:0] mm_asid;
    } commit_rec_t;

    typedef struct packed {
        logic                   int_pending;
        logic                   if_illegal;
        logic                   if_miss;
        logic                   if_invalid;
        logic                   syscall;
        logic                   reserved;
        logic                   cpu_unusable;
        logic                   overflow;
        logic                   eret;
        logic                   data_we;
        logic                   dm_illegal;
        logic                   dm_miss;
        logic                   dm_invalid;
        logic                   dm_dirty;
        logic [31:0]            pc;
        logic                   in_delayslot;
        logic [31:0]            mem_vaddr;
        logic [`EXC_ASID_W-1:0] if_asid;
        logic [`EXC_ASID_W-1:0] mm_asid;
    } fault_vec_t;

    typedef struct packed {
        logic        exl;
        logic        ie;
        logic        bev;
        logic        iv;
        logic        um;
        logic [7:0]  im;
        logic [1:0]  sw_ip;
        logic [31:0] epc;
        logic [19:0] ebase;
    } cp0_view_t;

    typedef struct packed {
        logic                   take;
        logic                   is_eret;
        exc_code_e              code;
        logic [31:0]            epc;
        logic                   bd;
        logic                   badv_we;
        logic [31:0]            bad_vaddr;
        logic                   asid_we;
        logic [`EXC_ASID_W-1:0] asid;
        logic [31:0]            new_pc;
    } trap_t;

    typedef struct packed {
        logic        valid;
        cp0_sel_e    sel;
        logic [31:0] data;
    } cp0_wr_t;

endpackage

`default_nettype wire

// ==== logic/exc_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module exc_decode (
    input  logic                    clk,
    input  logic                    reset,
    input  exc_pkg::commit_rec_t    commit,
    input  logic                    commit_valid,
    output logic                    commit_ready,
    input  logic [5:0]              hardware_int,
    input  exc_pkg::cp0_view_t      cp0,
    input  logic                    stage_advance,
    output exc_pkg::fault_vec_t     faults,
    output logic                    stage_valid
);

    exc_pkg::commit_rec_t rec_q;
    logic                 valid_q;
    logic                 accept;
    logic [7:0]           int_lines;
    logic                 int_enabled;
    logic                 user_mode;

    assign commit_ready = !valid_q || stage_advance;   // Empty or leaving
    assign accept       = commit_valid && commit_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (accept) begin
            valid_q <= 1'b1;
        end else if (stage_advance) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rec_q <= commit;
        end
    end

    // Interrupt lines checked against live CP0 state
    assign int_lines   = {hardware_int, cp0.sw_ip} & cp0.im;
    assign int_enabled = cp0.ie && !cp0.exl;
    assign user_mode   = cp0.um && !cp0.exl;

    always_comb begin
        faults.int_pending  = int_enabled && (int_lines != 8'h00);
        faults.if_illegal   = rec_q.if_illegal;
        faults.if_miss      = rec_q.if_miss;
        faults.if_invalid   = rec_q.if_invalid;
        faults.syscall      = rec_q.inst_class == exc_pkg::ic_syscall;
        faults.reserved     = rec_q.inst_class == exc_pkg::ic_reserved;
        faults.cpu_unusable = user_mode && (rec_q.inst_class == exc_pkg::ic_priv_op);
        faults.overflow     = rec_q.overflow;
        faults.eret         = rec_q.inst_class == exc_pkg::ic_eret;
        faults.data_we      = rec_q.inst_class == exc_pkg::ic_store;
        faults.dm_illegal   = rec_q.dm_illegal;
        faults.dm_miss      = rec_q.dm_miss;
        faults.dm_invalid   = rec_q.dm_invalid;
        faults.dm_dirty     = rec_q.dm_dirty;
        faults.pc           = rec_q.pc;
        faults.in_delayslot = rec_q.in_delayslot;
        faults.mem_vaddr    = rec_q.mem_vaddr;
        faults.if_asid      = rec_q.if_asid;
        faults.mm_asid      = rec_q.mm_asid;
    end

    assign stage_valid = valid_q;

    // Upstream must hold a stalled record
    assert property (@(posedge clk) disable iff (reset)
        (commit_valid && !commit_ready) |=> (commit_valid && $stable(commit)))
        else $error("exc_decode: commit changed while stalled");

endmodule

`default_nettype wire

// ==== logic/exc_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "exc_config.svh"

module exc_arbiter (
    input  exc_pkg::fault_vec_t faults,
    input  logic                stage_valid,
    input  exc_pkg::cp0_view_t  cp0,
    output exc_pkg::trap_t      trap
);

    logic [31:0] base;
    logic [31:0] epc_calc;
    logic        hit;

    assign base     = cp0.bev ? `EXC_BOOT_VECTOR : {cp0.ebase, 12'h000};
    assign epc_calc = faults.in_delayslot ? faults.pc - 32'd4 : faults.pc;

    always_comb begin
        hit            = 1'b1;
        trap.is_eret   = 1'b0;
        trap.code      = exc_pkg::exc_int;
        trap.epc       = epc_calc;
        trap.bd        = faults.in_delayslot;
        trap.badv_we   = 1'b0;
        trap.bad_vaddr = 32'h0;
        trap.asid_we   = 1'b0;
        trap.asid      = '0;
        trap.new_pc    = base + `EXC_OFF_GENERAL;

        if (faults.int_pending) begin
            if (cp0.iv) begin
                trap.new_pc = base + `EXC_OFF_INT;
            end
        end else if (faults.if_illegal) begin
            trap.code      = exc_pkg::exc_adel;
            trap.badv_we   = 1'b1;
            trap.bad_vaddr = faults.pc;
        end else if (faults.if_miss || faults.if_invalid) begin
            // Refill vector only for a miss outside EXL
            if (faults.if_miss && !cp0.exl) begin
                trap.new_pc = base + `EXC_OFF_REFILL;
            end
            trap.code      = exc_pkg::exc_tlbl;
            trap.badv_we   = 1'b1;
            trap.bad_vaddr = faults.pc;
            trap.asid_we   = 1'b1;
            trap.asid      = faults.if_asid;
        end else if (faults.syscall) begin
            trap.code = exc_pkg::exc_sys;
        end else if (faults.reserved) begin
            trap.code = exc_pkg::exc_ri;
        end else if (faults.cpu_unusable) begin
            trap.code = exc_pkg::exc_cpu;
        end else if (faults.overflow) begin
            trap.code = exc_pkg::exc_ov;
        end else if (faults.eret) begin
            trap.is_eret = 1'b1;    // Return without a cause update
            trap.new_pc  = cp0.epc;
        end else if (faults.dm_illegal) begin
            trap.code      = faults.data_we ? exc_pkg::exc_ades : exc_pkg::exc_adel;
            trap.badv_we   = 1'b1;
            trap.bad_vaddr = faults.mem_vaddr;
        end else if (faults.dm_miss || faults.dm_invalid || faults.dm_dirty) begin
            if (faults.dm_miss && !cp0.exl) begin
                trap.new_pc = base + `EXC_OFF_REFILL;
            end
            if (faults.dm_miss || faults.dm_invalid) begin
                trap.code = faults.data_we ? exc_pkg::exc_tlbs : exc_pkg::exc_tlbl;
            end else begin
                trap.code = exc_pkg::exc_mod;
            end
            trap.badv_we   = 1'b1;
            trap.bad_vaddr = faults.mem_vaddr;
            trap.asid_we   = 1'b1;
            trap.asid      = faults.mm_asid;
        end else begin
            hit = 1'b0;
        end

        trap.take = hit && stage_valid;
        if (!stage_valid) begin     // Empty stage writes nothing
            trap.is_eret = 1'b0;
            trap.badv_we = 1'b0;
            trap.asid_we = 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== logic/exc_cp0_regs.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "exc_config.svh"

module exc_cp0_regs (
    input  logic               clk,
    input  logic               reset,
    input  exc_pkg::trap_t     trap,
    input  logic               redirect_ready,
    output logic               redirect_valid,
    output logic [31:0]        redirect_pc,
    output logic               stage_advance,
    input  exc_pkg::cp0_wr_t   cp0_wr,
    input  exc_pkg::cp0_sel_e  cp0_rd_sel,
    output logic [31:0]        cp0_rd_data,
    output exc_pkg::cp0_view_t cp0
);

    logic                   status_exl;
    logic                   status_ie;
    logic                   status_bev;
    logic                   status_um;
    logic [7:0]             status_im;
    logic                   cause_bd;
    logic                   cause_iv;
    logic [1:0]             cause_sw_ip;
    exc_pkg::exc_code_e     cause_code;
    logic [31:0]            epc_q;
    logic [31:0]            badvaddr_q;
    logic [`EXC_ASID_W-1:0] asid_q;
    logic [19:0]            ebase_q;
    logic                   exc_wb;
    logic                   sw_we;

    assign stage_advance = !redirect_valid || redirect_ready;
    assign exc_wb        = trap.take && stage_advance;
    assign sw_we         = cp0_wr.valid && !exc_wb;    // Exception wins

    always_ff @(posedge clk) begin
        if (reset) begin
            status_exl     <= 1'b1;
            status_ie      <= 1'b0;
            status_bev     <= 1'b1;
            status_um      <= 1'b0;
            status_im      <= 8'h00;
            cause_bd       <= 1'b0;
            cause_iv       <= 1'b0;
            cause_sw_ip    <= 2'b00;
            cause_code     <= exc_pkg::exc_int;
            ebase_q        <= `EXC_EBASE_RESET;
            redirect_valid <= 1'b0;
        end else begin
            if (sw_we) begin
                case (cp0_wr.sel)
                    exc_pkg::sel_status: begin
                        status_bev <= cp0_wr.data[22];
                        status_im  <= cp0_wr.data[15:8];
                        status_um  <= cp0_wr.data[4];
                        status_exl <= cp0_wr.data[1];
                        status_ie  <= cp0_wr.data[0];
                    end
                    exc_pkg::sel_cause: begin
                        cause_iv    <= cp0_wr.data[23];
                        cause_sw_ip <= cp0_wr.data[9:8];
                    end
                    exc_pkg::sel_ebase: ebase_q <= cp0_wr.data[31:12];
                    default: ;
                endcase
            end
            if (exc_wb) begin
                if (trap.is_eret) begin
                    status_exl <= 1'b0;
                end else begin
                    status_exl <= 1'b1;
                    cause_code <= trap.code;
                    if (!status_exl) begin
                        cause_bd <= trap.bd;    // BD tracks EPC
                    end
                end
            end
            if (exc_wb) begin
                redirect_valid <= 1'b1;
            end else if (redirect_ready) begin
                redirect_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (exc_wb && !trap.is_eret && !status_exl) begin
            epc_q <= trap.epc;
        end else if (sw_we && cp0_wr.sel == exc_pkg::sel_epc) begin
            epc_q <= cp0_wr.data;
        end
        if (exc_wb && trap.badv_we) begin
            badvaddr_q <= trap.bad_vaddr;
        end
        if (exc_wb && trap.asid_we) begin
            asid_q <= trap.asid;
        end else if (sw_we && cp0_wr.sel == exc_pkg::sel_entryhi) begin
            asid_q <= cp0_wr.data[`EXC_ASID_W-1:0];
        end
        if (exc_wb) begin
            redirect_pc <= trap.new_pc;
        end
    end

    always_comb begin
        case (cp0_rd_sel)
            exc_pkg::sel_status:
                cp0_rd_data = {9'b0, status_bev, 6'b0, status_im, 3'b0, status_um,
                               2'b0, status_exl, status_ie};
            exc_pkg::sel_cause:
                cp0_rd_data = {cause_bd, 7'b0, cause_iv, 13'b0, cause_sw_ip, 1'b0,
                               cause_code, 2'b0};
            exc_pkg::sel_epc:      cp0_rd_data = epc_q;
            exc_pkg::sel_badvaddr: cp0_rd_data = badvaddr_q;
            exc_pkg::sel_entryhi:  cp0_rd_data = {{(32-`EXC_ASID_W){1'b0}}, asid_q};
            exc_pkg::sel_ebase:    cp0_rd_data = {ebase_q, 12'h000};
            default:               cp0_rd_data = 32'h0;
        endcase
    end

    always_comb begin
        cp0.exl   = status_exl;
        cp0.ie    = status_ie;
        cp0.bev   = status_bev;
        cp0.iv    = cause_iv;
        cp0.um    = status_um;
        cp0.im    = status_im;
        cp0.sw_ip = cause_sw_ip;
        cp0.epc   = epc_q;
        cp0.ebase = ebase_q;
    end

    // Pending redirect held until fetch takes it
    assert property (@(posedge clk) disable iff (reset)
        (redirect_valid && !redirect_ready) |=> (redirect_valid && $stable(redirect_pc)))
        else $error("exc_cp0_regs: redirect dropped or changed without redirect_ready");

endmodule

`default_nettype wire

// ==== logic/exc_unit_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module exc_unit_top (
    input  logic                 clk,
    input  logic                 reset,
    input  exc_pkg::commit_rec_t commit,
    input  logic                 commit_valid,
    output logic                 commit_ready,
    input  logic [5:0]           hardware_int,
    output logic                 redirect_valid,
    input  logic                 redirect_ready,
    output logic [31:0]          redirect_pc,
    input  exc_pkg::cp0_wr_t     cp0_wr,
    input  exc_pkg::cp0_sel_e    cp0_rd_sel,
    output logic [31:0]          cp0_rd_data
);

    exc_pkg::fault_vec_t faults;
    exc_pkg::trap_t      trap;
    exc_pkg::cp0_view_t  cp0;
    logic                stage_valid;
    logic                stage_advance;

    exc_decode u_decode (
        .clk           (clk),
        .reset         (reset),
        .commit        (commit),
        .commit_valid  (commit_valid),
        .commit_ready  (commit_ready),
        .hardware_int  (hardware_int),
        .cp0           (cp0),
        .stage_advance (stage_advance),
        .faults        (faults),
        .stage_valid   (stage_valid)
    );

    exc_arbiter u_arbiter (
        .faults      (faults),
        .stage_valid (stage_valid),
        .cp0         (cp0),
        .trap        (trap)
    );

    exc_cp0_regs u_cp0 (
        .clk            (clk),
        .reset          (reset),
        .trap           (trap),
        .redirect_ready (redirect_ready),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .stage_advance  (stage_advance),
        .cp0_wr         (cp0_wr),
        .cp0_rd_sel     (cp0_rd_sel),
        .cp0_rd_data    (cp0_rd_data),
        .cp0            (cp0)
    );

endmodule

`default_nettype wire

// ==== verification/tb_exc_unit.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "exc_config.svh"

module tb_exc_unit;

    localparam int TIMEOUT = 50;

    logic                 clk;
    logic                 reset;
    exc_pkg::commit_rec_t commit;
    logic                 commit_valid;
    logic                 commit_ready;
    logic [5:0]           hardware_int;
    logic                 redirect_valid;
    logic                 redirect_ready;
    logic [31:0]          redirect_pc;
    exc_pkg::cp0_wr_t     cp0_wr;
    exc_pkg::cp0_sel_e    cp0_rd_sel;
    logic [31:0]          cp0_rd_data;

    // Expected CP0 state
    logic        m_exl;
    logic        m_ie;
    logic        m_bev;
    logic        m_iv;
    logic        m_um;
    logic [7:0]  m_im;
    logic [1:0]  m_sw_ip;
    logic [31:0] m_epc;
    logic [19:0] m_ebase;
    logic [31:0] seen_pc;    // Last redirect taken from the DUT
    int          error_count;

    exc_unit_top dut0 (
        .clk            (clk),
        .reset          (reset),
        .commit         (commit),
        .commit_valid   (commit_valid),
        .commit_ready   (commit_ready),
        .hardware_int   (hardware_int),
        .redirect_valid (redirect_valid),
        .redirect_ready (redirect_ready),
        .redirect_pc    (redirect_pc),
        .cp0_wr         (cp0_wr),
        .cp0_rd_sel     (cp0_rd_sel),
        .cp0_rd_data    (cp0_rd_data)
    );

    always #50 clk = ~clk;

    task automatic abort_run(input string what);
        error_count += 1;
        $display("%s", what);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic cmp_pc(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("** Error: %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic cmp_code(input string name, input exc_pkg::exc_code_e got,
                            input exc_pkg::exc_code_e exp);
        if (got !== exp) begin
            abort_run($sformatf("** Error: %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic read_cp0(input exc_pkg::cp0_sel_e sel, output logic [31:0] data);
        @(negedge clk);
        cp0_rd_sel = sel;
        #1;
        data = cp0_rd_data;
    endtask

    task automatic cmp_word(input string name, input exc_pkg::cp0_sel_e sel,
                            input logic [31:0] exp);
        logic [31:0] w;
        read_cp0(sel, w);
        if (w !== exp) begin
            abort_run($sformatf("** Error: cp0 %s got %h expected %h", name, w, exp));
        end
    endtask

    task automatic check_cause_code(input exc_pkg::exc_code_e exp);
        logic [31:0] w;
        read_cp0(exc_pkg::sel_cause, w);
        cmp_code("cause.exc_code", exc_pkg::exc_code_e'(w[6:2]), exp);
    endtask

    task automatic cp0_write(input exc_pkg::cp0_sel_e sel, input logic [31:0] data);
        @(negedge clk);
        cp0_wr.valid = 1'b1;
        cp0_wr.sel   = sel;
        cp0_wr.data  = data;
        @(negedge clk);
        cp0_wr.valid = 1'b0;
        case (sel)
            exc_pkg::sel_status: begin
                m_bev = data[22];
                m_im  = data[15:8];
                m_um  = data[4];
                m_exl = data[1];
                m_ie  = data[0];
            end
            exc_pkg::sel_cause: begin
                m_iv    = data[23];
                m_sw_ip = data[9:8];
            end
            exc_pkg::sel_epc:   m_epc = data;
            exc_pkg::sel_ebase: m_ebase = data[31:12];
            default: ;
        endcase
    endtask

    // MIPS exception priority, interrupts first and data faults last
    task automatic predict(input exc_pkg::commit_rec_t rec, output exc_pkg::trap_t t);
        logic [31:0] base;
        logic        irq;
        logic        is_store;
        base     = m_bev ? `EXC_BOOT_VECTOR : {m_ebase, 12'h000};
        irq      = m_ie && !m_exl && ((({hardware_int, m_sw_ip}) & m_im) != 8'h00);
        is_store = rec.inst_class == exc_pkg::ic_store;
        t        = '0;
        t.take   = 1'b1;
        t.epc    = rec.in_delayslot ? rec.pc - 32'd4 : rec.pc;
        t.bd     = rec.in_delayslot;
        t.new_pc = base + `EXC_OFF_GENERAL;
        if (irq) begin
            t.code = exc_pkg::exc_int;
            if (m_iv) t.new_pc = base + `EXC_OFF_INT;
        end else if (rec.if_illegal) begin
            t.code      = exc_pkg::exc_adel;
            t.badv_we   = 1'b1;
            t.bad_vaddr = rec.pc;
        end else if (rec.if_miss || rec.if_invalid) begin
            t.code      = exc_pkg::exc_tlbl;
            t.badv_we   = 1'b1;
            t.bad_vaddr = rec.pc;
            t.asid_we   = 1'b1;
            t.asid      = rec.if_asid;
            if (rec.if_miss && !m_exl) t.new_pc = base + `EXC_OFF_REFILL;
        end else if (rec.inst_class == exc_pkg::ic_syscall) begin
            t.code = exc_pkg::exc_sys;
        end else if (rec.inst_class == exc_pkg::ic_reserved) begin
            t.code = exc_pkg::exc_ri;
        end else if (rec.inst_class == exc_pkg::ic_priv_op && m_um && !m_exl) begin
            t.code = exc_pkg::exc_cpu;
        end else if (rec.overflow) begin
            t.code = exc_pkg::exc_ov;
        end else if (rec.inst_class == exc_pkg::ic_eret) begin
            t.is_eret = 1'b1;
            t.new_pc  = m_epc;
        end else if (rec.dm_illegal) begin
            t.code      = is_store ? exc_pkg::exc_ades : exc_pkg::exc_adel;
            t.badv_we   = 1'b1;
            t.bad_vaddr = rec.mem_vaddr;
        end else if (rec.dm_miss || rec.dm_invalid || rec.dm_dirty) begin
            if (rec.dm_miss || rec.dm_invalid) begin
                t.code = is_store ? exc_pkg::exc_tlbs : exc_pkg::exc_tlbl;
            end else begin
                t.code = exc_pkg::exc_mod;    // Store to clean page
            end
            t.badv_we   = 1'b1;
            t.bad_vaddr = rec.mem_vaddr;
            t.asid_we   = 1'b1;
            t.asid      = rec.mm_asid;
            if (rec.dm_miss && !m_exl) t.new_pc = base + `EXC_OFF_REFILL;
        end else begin
            t.take = 1'b0;
        end
    endtask

    task automatic apply_trap(input exc_pkg::trap_t t);
        if (t.is_eret) begin
            m_exl = 1'b0;
        end else begin
            if (!m_exl) m_epc = t.epc;
            m_exl = 1'b1;
        end
    endtask

    task automatic commit_one(input exc_pkg::commit_rec_t rec);
        int n;
        n = 0;
        @(negedge clk);
        commit       = rec;
        commit_valid = 1'b1;
        #1;
        while (!commit_ready) begin
            if (n == TIMEOUT) begin
                abort_run("Timeout: commit_ready never went high");
            end
            n++;
            @(negedge clk);
            #1;
        end
        @(posedge clk);     // Record transfers here
        @(negedge clk);
        commit_valid = 1'b0;
    endtask

    task automatic wait_valid();
        int n;
        n = 0;
        while (!redirect_valid) begin
            if (n == TIMEOUT) begin
                abort_run("Timeout: redirect_valid never went high");
            end
            n++;
            @(negedge clk);
        end
    endtask

    task automatic wait_redirect(input logic [31:0] exp);
        wait_valid();
        seen_pc = redirect_pc;
        cmp_pc("redirect_pc", redirect_pc, exp);
        if (redirect_ready) @(negedge clk);
    endtask

    task automatic expect_quiet(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            if (redirect_valid) begin
                abort_run("Unexpected redirect for an instruction that should retire");
            end
        end
    endtask

    task automatic run_record(input exc_pkg::commit_rec_t rec);
        exc_pkg::trap_t t;
        predict(rec, t);
        commit_one(rec);
        if (t.take) begin
            wait_redirect(t.new_pc);
            apply_trap(t);
            if (!t.is_eret) begin
                check_cause_code(t.code);
                cmp_word("epc", exc_pkg::sel_epc, m_epc);
                if (t.badv_we) cmp_word("badvaddr", exc_pkg::sel_badvaddr, t.bad_vaddr);
                if (t.asid_we) cmp_word("entryhi", exc_pkg::sel_entryhi, {24'h0, t.asid});
            end
        end else begin
            expect_quiet(4);
        end
    endtask

    function automatic exc_pkg::commit_rec_t make_rec(input exc_pkg::inst_class_e cls);
        exc_pkg::commit_rec_t r;
        r            = '0;
        r.pc         = $urandom & 32'hffff_fffc;
        r.inst_class = cls;
        r.mem_vaddr  = $urandom;
        r.if_asid    = 8'($urandom);
        r.mm_asid    = 8'($urandom);
        return r;
    endfunction

    task automatic make_random(output exc_pkg::commit_rec_t r);
        r              = make_rec(exc_pkg::inst_class_e'(3'($urandom_range(0, 6))));
        r.in_delayslot = 1'($urandom_range(0, 1));
        r.if_illegal   = $urandom_range(0, 5) == 0;
        r.if_miss      = $urandom_range(0, 5) == 0;
        r.if_invalid   = $urandom_range(0, 5) == 0;
        r.overflow     = $urandom_range(0, 3) == 0;
        r.dm_illegal   = $urandom_range(0, 3) == 0;
        r.dm_miss      = $urandom_range(0, 3) == 0;
        r.dm_invalid   = $urandom_range(0, 3) == 0;
        r.dm_dirty     = $urandom_range(0, 3) == 0;
    endtask

    task automatic syscall_at_boot();
        exc_pkg::commit_rec_t r;
        cp0_write(exc_pkg::sel_status, 32'h0040_0000);    // BEV kept, EXL cleared
        r = make_rec(exc_pkg::ic_syscall);
        run_record(r);
        cmp_pc("redirect_pc", seen_pc, 32'hbfc0_0380);
        cmp_word("cause", exc_pkg::sel_cause, 32'h0000_0020);
        cmp_word("epc", exc_pkg::sel_epc, r.pc);
    endtask

    task automatic tlb_store_then_eret();
        exc_pkg::commit_rec_t r;
        exc_pkg::commit_rec_t e;
        cp0_write(exc_pkg::sel_status, 32'h0000_0000);
        r         = make_rec(exc_pkg::ic_store);
        r.dm_miss = 1'b1;
        run_record(r);
        cmp_pc("redirect_pc", seen_pc, 32'h8000_0000);
        check_cause_code(exc_pkg::exc_tlbs);
        cmp_word("badvaddr", exc_pkg::sel_badvaddr, r.mem_vaddr);
        cmp_word("entryhi", exc_pkg::sel_entryhi, {24'h0, r.mm_asid});
        e = make_rec(exc_pkg::ic_eret);
        run_record(e);
        cmp_pc("redirect_pc", seen_pc, r.pc);
        cmp_word("status", exc_pkg::sel_status, 32'h0000_0000);
    endtask

    task automatic priority_mix();
        exc_pkg::commit_rec_t r;
        logic                 um;
        for (int i = 0; i < 24; i++) begin
            um = 1'($urandom_range(0, 1));
            cp0_write(exc_pkg::sel_status, {27'h0, um, 4'h0});
            make_random(r);
            run_record(r);
        end
    endtask

    task automatic interrupt_vectors();
        cp0_write(exc_pkg::sel_status, 32'h0000_ff01);
        @(negedge clk);
        hardware_int = 6'h04;
        run_record(make_rec(exc_pkg::ic_plain));
        cmp_pc("redirect_pc", seen_pc, 32'h8000_0180);
        check_cause_code(exc_pkg::exc_int);
        cp0_write(exc_pkg::sel_cause, 32'h0080_0000);     // IV on
        cp0_write(exc_pkg::sel_status, 32'h0000_ff01);
        run_record(make_rec(exc_pkg::ic_plain));
        cmp_pc("redirect_pc", seen_pc, 32'h8000_0200);
        @(negedge clk);
        hardware_int = 6'h00;
        cp0_write(exc_pkg::sel_cause, 32'h0000_0000);
    endtask

    task automatic delay_slot_epc();
        exc_pkg::commit_rec_t r;
        cp0_write(exc_pkg::sel_status, 32'h0000_0000);
        r              = make_rec(exc_pkg::ic_plain);
        r.overflow     = 1'b1;
        r.in_delayslot = 1'b1;
        run_record(r);
        cmp_word("epc", exc_pkg::sel_epc, r.pc - 32'd4);
        cmp_word("cause", exc_pkg::sel_cause, 32'h8000_0030);
        // EXL now set, EPC must hold
        run_record(make_rec(exc_pkg::ic_syscall));
        cmp_word("epc", exc_pkg::sel_epc, r.pc - 32'd4);
    endtask

    task automatic redirect_backpressure();
        exc_pkg::trap_t t;
        exc_pkg::commit_rec_t r;
        logic [31:0] held;
        int n;
        cp0_write(exc_pkg::sel_status, 32'h0000_0000);
        @(negedge clk);
        redirect_ready = 1'b0;
        r = make_rec(exc_pkg::ic_syscall);
        predict(r, t);
        commit_one(r);
        wait_valid();
        apply_trap(t);
        cmp_pc("redirect_pc", redirect_pc, t.new_pc);
        held = redirect_pc;
        commit_one(make_rec(exc_pkg::ic_plain));      // Fills the stage
        @(negedge clk);
        commit       = make_rec(exc_pkg::ic_plain);
        commit_valid = 1'b1;
        n = 0;
        #1;
        while (commit_ready) begin
            if (n == TIMEOUT) begin
                abort_run("Timeout: commit_ready did not drop under back-pressure");
            end
            n++;
            @(negedge clk);
            #1;
        end
        repeat (3) begin
            @(negedge clk);
            #1;
            if (!redirect_valid || commit_ready) begin
                abort_run("Redirect or stall released while redirect_ready was low");
            end
            cmp_pc("redirect_pc", redirect_pc, held);
        end
        @(negedge clk);
        redirect_ready = 1'b1;
        #1;
        if (!commit_ready) begin
            abort_run("commit_ready stayed low after redirect_ready was raised");
        end
        @(posedge clk);
        @(negedge clk);
        commit_valid = 1'b0;
        expect_quiet(6);
    endtask

    initial begin
        void'($urandom(32'h437a_fd59));
        clk            = 1'b0;
        reset          = 1'b1;
        commit         = '0;
        commit_valid   = 1'b0;
        hardware_int   = 6'h00;
        redirect_ready = 1'b1;
        cp0_wr         = '0;
        cp0_rd_sel     = exc_pkg::sel_status;
        error_count    = 0;
        seen_pc        = 32'h0;
        m_exl          = 1'b1;
        m_ie           = 1'b0;
        m_bev          = 1'b1;
        m_iv           = 1'b0;
        m_um           = 1'b0;
        m_im           = 8'h00;
        m_sw_ip        = 2'b00;
        m_epc          = 32'h0;
        m_ebase        = `EXC_EBASE_RESET;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        cmp_word("status", exc_pkg::sel_status, 32'h0040_0002);
        cmp_word("ebase", exc_pkg::sel_ebase, 32'h8000_0000);
        syscall_at_boot();
        tlb_store_then_eret();
        priority_mix();
        interrupt_vectors();
        delay_slot_epc();
        redirect_backpressure();

        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+logic
logic/exc_pkg.sv
logic/exc_decode.sv
logic/exc_arbiter.sv
logic/exc_cp0_regs.sv
logic/exc_unit_top.sv
verification/tb_exc_unit.sv
